// File: logic/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// line and set geometry, log2 of bytes and sets
`define ICACHE_LEN_LINE 5
`define ICACHE_LEN_INDEX 4
// one LRU bit per set only covers two ways
`define ICACHE_NR_WAYS 2

`define ICACHE_LEN_TAG (32 - `ICACHE_LEN_LINE - `ICACHE_LEN_INDEX)
`define ICACHE_NR_WORDS (1 << (`ICACHE_LEN_LINE - 2))
`define ICACHE_NR_SETS (1 << `ICACHE_LEN_INDEX)
// data ram entries are 64-bit word pairs
`define ICACHE_LEN_RAM_ADDR (`ICACHE_LEN_INDEX + `ICACHE_LEN_LINE - 3)
`define ICACHE_LEN_WAY_SEL ($clog2(`ICACHE_NR_WAYS))

// kseg0 and kseg1 share va[31:30], va[29] selects kseg1
`define ICACHE_SEG_UNMAPPED 2'b10
`define ICACHE_KSEG1_BIT 29

`endif

// File: logic/icache_pkg.sv
`include "icache_params.svh"

package icache_pkg;

    // even/odd page pair from the joint TLB
    typedef struct packed {
        logic [18:0] vpn2;
        logic [19:0] pfn0;
        logic [19:0] pfn1;
        logic        v0;
        logic        v1;
        logic        c0;
        logic        c1;
    } tlb_entry;

    typedef struct packed {
        logic                       valid;
        logic [`ICACHE_LEN_TAG-1:0] tag;
    } icache_tag;

    typedef struct packed {
        logic [18:0] vpn2;
        logic        odd;
        logic [11:0] offset;
    } va_tlb_s;

    typedef struct packed {
        logic [`ICACHE_LEN_TAG-1:0]   tag;
        logic [`ICACHE_LEN_INDEX-1:0] index;
        logic [`ICACHE_LEN_LINE-3:0]  word;
        logic [1:0]                   byte_off;
    } va_cache_s;

    // same fetch address, seen by the TLB and by the cache
    typedef union packed {
        va_tlb_s   tlb;
        va_cache_s cache;
    } vaddr_u;

    typedef struct packed {
        logic [`ICACHE_LEN_INDEX-1:0] addr;
        logic [`ICACHE_LEN_LINE-3:0]  cnt;
        logic [31:0]                  wdata;
        icache_tag                    tag;
        logic                         fill;
    } way_wr_s;

    typedef struct packed {
        logic [63:0] data;
        logic        hit;
    } way_rd_s;

endpackage

// File: logic/icache_way.sv
`include "icache_params.svh"

module icache_way (
    input  logic                           clk,
    input  logic [`ICACHE_LEN_RAM_ADDR-1:0] rd_addr,
    input  logic [`ICACHE_LEN_TAG-1:0]     cache_tag,
    input  icache_pkg::way_wr_s            way_wr,
    input  logic                           data_we,
    input  logic                           tag_we,
    output icache_pkg::way_rd_s            way_rd
);

    logic [63:0] data_ram [1 << `ICACHE_LEN_RAM_ADDR];
    icache_pkg::icache_tag tag_ram [`ICACHE_NR_SETS];

    logic [63:0] rd_data;
    icache_pkg::icache_tag rd_tag;
    logic [`ICACHE_LEN_RAM_ADDR-1:0] wr_addr;
    logic [1:0] half_we;

    // word pair inside the line being filled
    assign wr_addr = {way_wr.addr, way_wr.cnt[`ICACHE_LEN_LINE-3:1]};

    // even words go low, odd words go high
    assign half_we[0] = data_we && way_wr.fill && !way_wr.cnt[0];
    assign half_we[1] = data_we && way_wr.fill && way_wr.cnt[0];

    always_ff @(posedge clk) begin
        for (int h = 0; h < 2; h++) begin
            if (half_we[h]) begin
                data_ram[wr_addr][h*32 +: 32] <= way_wr.wdata;
            end
        end
        rd_data <= data_ram[rd_addr];
    end

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_ram[way_wr.addr] <= way_wr.tag;
        end
        rd_tag <= tag_ram[rd_addr[`ICACHE_LEN_RAM_ADDR-1 -: `ICACHE_LEN_INDEX]];
    end

    // physical tag arrives in the cycle the read data is out
    assign way_rd.data = rd_data;
    assign way_rd.hit  = rd_tag.valid && (rd_tag.tag == cache_tag);

endmodule

// File: logic/icache_hit_select.sv
`include "icache_params.svh"

module icache_hit_select (
    input  logic                                 inst_va2,
    input  icache_pkg::way_rd_s                  way_rd [`ICACHE_NR_WAYS],
    output logic                                 hit,
    output logic [`ICACHE_LEN_WAY_SEL-1:0]       hit_way,
    output logic [31:0]                          hit_inst0,
    output logic [31:0]                          hit_inst1
);

    localparam int way_sel_w = `ICACHE_LEN_WAY_SEL;

    logic [`ICACHE_NR_WAYS-1:0] hit_vec;
    logic [63:0] pair;

    always_comb begin
        hit_way = '0;
        pair    = way_rd[0].data;
        for (int i = 0; i < `ICACHE_NR_WAYS; i++) begin
            hit_vec[i] = way_rd[i].hit;
            // at most one way holds a given tag
            if (way_rd[i].hit) begin
                hit_way = way_sel_w'(i);
                pair    = way_rd[i].data;
            end
        end
    end

    assign hit = |hit_vec;

    // second word only valid for an even fetch address
    assign hit_inst0 = inst_va2 ? pair[63:32] : pair[31:0];
    assign hit_inst1 = pair[63:32];

endmodule

// File: logic/icache_ctrl.sv
`include "icache_params.svh"

module icache_ctrl (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             inst_en,
    input  logic [31:0]                      inst_va,
    input  logic [31:0]                      inst_va_next,
    output logic [31:0]                      inst_rdata0,
    output logic [31:0]                      inst_rdata1,
    output logic                             inst_ok0,
    output logic                             inst_ok1,
    output logic                             inst_tlb_refill,
    output logic                             inst_tlb_invalid,
    input  logic                             stallF,
    output logic                             istall,
    input  logic                             fence_i,
    input  logic [31:0]                      fence_addr,
    input  logic                             fence_tlb,
    output logic [18:0]                      itlb_vpn2,
    input  logic                             itlb_found,
    input  icache_pkg::tlb_entry             itlb_entry,
    output logic [31:0]                      araddr,
    output logic [7:0]                       arlen,
    output logic [2:0]                       arsize,
    output logic                             arvalid,
    input  logic                             arready,
    input  logic [31:0]                      rdata,
    input  logic                             rlast,
    input  logic                             rvalid,
    output logic                             rready,
    output logic [`ICACHE_LEN_RAM_ADDR-1:0]  rd_addr,
    output icache_pkg::way_wr_s              way_wr,
    output logic [`ICACHE_NR_WAYS-1:0]       data_we,
    output logic [`ICACHE_NR_WAYS-1:0]       tag_we,
    output logic [`ICACHE_LEN_TAG-1:0]       cache_tag,
    input  logic                             hit,
    input  logic [`ICACHE_LEN_WAY_SEL-1:0]   hit_way,
    input  logic [31:0]                      hit_inst0,
    input  logic [31:0]                      hit_inst1
);

    typedef enum logic [2:0] {
        s_idle, s_fence, s_tlb_fill, s_uncached, s_refill, s_save
    } state_t;

    state_t state;

    icache_pkg::vaddr_u va;
    icache_pkg::vaddr_u va_next;
    icache_pkg::vaddr_u fence_va;

    // one-entry L1 iTLB, a single 4K page
    logic [19:0] l1_vpn;
    logic [19:0] l1_pfn;
    logic        l1_uncached;
    logic        l1_valid;

    logic        fence_i_ready;
    logic        fence_tlb_ready;
    logic [`ICACHE_NR_SETS-1:0] lru;
    logic [`ICACHE_LEN_WAY_SEL-1:0] victim;
    logic [`ICACHE_LEN_LINE-3:0] beat_cnt;
    logic [31:0] saved_inst0;

    logic        direct_mapped;
    logic        uncached;
    logic        translation_ok;
    logic [19:0] pfn;
    logic [31:0] inst_pa;
    logic        fence_pending;
    logic        hit_ok;
    logic        idle_req;
    logic        fence_start;
    logic        tlb_fence_start;
    logic        tlb_start;
    logic        unc_start;
    logic        miss_start;
    logic        beat;
    logic        page_valid;

    assign va       = inst_va;
    assign va_next  = inst_va_next;
    assign fence_va = fence_addr;

    // kseg0/kseg1 bypass the TLB
    assign direct_mapped  = inst_va[31:30] == `ICACHE_SEG_UNMAPPED;
    assign uncached       = direct_mapped ? inst_va[`ICACHE_KSEG1_BIT] : l1_uncached;
    assign pfn            = direct_mapped ? {3'b000, inst_va[28:12]} : l1_pfn;
    assign inst_pa        = {pfn, va.tlb.offset};
    assign translation_ok = direct_mapped || (l1_valid && l1_vpn == {va.tlb.vpn2, va.tlb.odd});
    assign cache_tag      = inst_pa[31 -: `ICACHE_LEN_TAG];

    assign fence_pending = (fence_i && !fence_i_ready) || (fence_tlb && !fence_tlb_ready);
    assign hit_ok        = hit && translation_ok && !uncached && !fence_pending;

    assign idle_req        = state == s_idle && inst_en;
    assign fence_start     = idle_req && fence_i && !fence_i_ready;
    assign tlb_fence_start = idle_req && !fence_start && fence_tlb && !fence_tlb_ready;
    assign tlb_start       = idle_req && !fence_pending && !translation_ok;
    assign unc_start       = idle_req && !fence_pending && translation_ok && uncached;
    assign miss_start      = idle_req && !fence_pending && translation_ok && !uncached && !hit;
    assign beat            = rvalid && rready;

    assign page_valid = va.tlb.odd ? itlb_entry.v1 : itlb_entry.v0;

    // rams look one cycle ahead only while the fetch port can advance
    assign rd_addr = (state != s_idle && state != s_save) ?
                     {va.cache.index, va.cache.word[`ICACHE_LEN_LINE-3:1]} :
                     {va_next.cache.index, va_next.cache.word[`ICACHE_LEN_LINE-3:1]};

    assign istall      = (state == s_idle) ? (inst_en && !hit_ok) : (state != s_save);
    assign inst_ok0    = inst_en && ((state == s_idle) ? hit_ok : (state == s_save));
    assign inst_ok1    = inst_en && state == s_idle && hit_ok && !inst_va[2];
    assign inst_rdata0 = (state == s_idle) ? hit_inst0 : saved_inst0;
    assign inst_rdata1 = (state == s_idle) ? hit_inst1 : 32'h0;

    assign arsize = 3'd2;

    // fence clears the tag in the detect cycle, so the fence cycle reads it back
    always_comb begin
        way_wr.addr      = fence_start ? fence_va.cache.index : va.cache.index;
        way_wr.cnt       = beat_cnt;
        way_wr.wdata     = rdata;
        way_wr.tag.valid = !fence_start;
        way_wr.tag.tag   = cache_tag;
        way_wr.fill      = state == s_refill && beat;
        for (int i = 0; i < `ICACHE_NR_WAYS; i++) begin
            data_we[i] = state == s_refill && victim == i;
            tag_we[i]  = fence_start || (way_wr.fill && rlast && victim == i);
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_start) begin
            itlb_vpn2 <= va.tlb.vpn2;
        end
        if (unc_start) begin
            araddr <= inst_pa;
            arlen  <= 8'd0;
        end else if (miss_start) begin
            araddr <= {inst_pa[31:`ICACHE_LEN_LINE], {`ICACHE_LEN_LINE{1'b0}}};
            arlen  <= 8'(`ICACHE_NR_WORDS - 1);
            victim <= lru[va.cache.index];
        end
        if (miss_start) begin
            beat_cnt <= '0;
        end else if (way_wr.fill) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
        // exceptions return a zero word
        if (state == s_uncached && beat) begin
            saved_inst0 <= rdata;
        end else if (state == s_tlb_fill) begin
            saved_inst0 <= 32'h0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= s_idle;
            l1_vpn           <= '0;
            l1_pfn           <= '0;
            l1_uncached      <= 1'b0;
            l1_valid         <= 1'b0;
            inst_tlb_refill  <= 1'b0;
            inst_tlb_invalid <= 1'b0;
            fence_i_ready    <= 1'b0;
            fence_tlb_ready  <= 1'b0;
            arvalid          <= 1'b0;
            rready           <= 1'b0;
            lru              <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (fence_start || tlb_fence_start) begin
                        l1_valid <= 1'b0;
                        state    <= s_fence;
                    end else if (tlb_start) begin
                        state <= s_tlb_fill;
                    end else if (unc_start) begin
                        arvalid <= 1'b1;
                        state   <= s_uncached;
                    end else if (miss_start) begin
                        arvalid <= 1'b1;
                        state   <= s_refill;
                    end else if (idle_req && hit_ok && !stallF) begin
                        fence_i_ready   <= 1'b0;
                        fence_tlb_ready <= 1'b0;
                        // two ways, so the other one goes next
                        lru[va.cache.index] <= ~hit_way;
                    end
                end
                s_fence: begin
                    fence_i_ready   <= 1'b1;
                    fence_tlb_ready <= 1'b1;
                    state           <= s_idle;
                end
                s_tlb_fill: begin
                    if (itlb_found && page_valid) begin
                        l1_vpn      <= {va.tlb.vpn2, va.tlb.odd};
                        l1_pfn      <= va.tlb.odd ? itlb_entry.pfn1 : itlb_entry.pfn0;
                        l1_uncached <= va.tlb.odd ? !itlb_entry.c1 : !itlb_entry.c0;
                        l1_valid    <= 1'b1;
                        state       <= s_idle;
                    end else begin
                        inst_tlb_invalid <= itlb_found;
                        inst_tlb_refill  <= !itlb_found;
                        state            <= s_save;
                    end
                end
                s_uncached: begin
                    if (arvalid) begin
                        if (arready) begin
                            arvalid <= 1'b0;
                            rready  <= 1'b1;
                        end
                    end else if (beat) begin
                        rready <= 1'b0;
                        state  <= s_save;
                    end
                end
                s_refill: begin
                    if (arvalid) begin
                        if (arready) begin
                            arvalid <= 1'b0;
                            rready  <= 1'b1;
                        end
                    end else if (beat) begin
                        if (rlast) begin
                            rready <= 1'b0;
                        end
                    end else if (!rready) begin
                        // last word written, retry as a hit
                        state <= s_idle;
                    end
                end
                s_save: begin
                    if (!stallF) begin
                        fence_i_ready    <= 1'b0;
                        fence_tlb_ready  <= 1'b0;
                        inst_tlb_refill  <= 1'b0;
                        inst_tlb_invalid <= 1'b0;
                        state            <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

// File: logic/icache_top.sv
`include "icache_params.svh"

module icache_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 inst_en,
    input  logic [31:0]          inst_va,
    input  logic [31:0]          inst_va_next,
    output logic [31:0]          inst_rdata0,
    output logic [31:0]          inst_rdata1,
    output logic                 inst_ok0,
    output logic                 inst_ok1,
    output logic                 inst_tlb_refill,
    output logic                 inst_tlb_invalid,
    input  logic                 stallF,
    output logic                 istall,
    input  logic                 fence_i,
    input  logic [31:0]          fence_addr,
    input  logic                 fence_tlb,
    output logic [18:0]          itlb_vpn2,
    input  logic                 itlb_found,
    input  icache_pkg::tlb_entry itlb_entry,
    output logic [31:0]          araddr,
    output logic [7:0]           arlen,
    output logic [2:0]           arsize,
    output logic                 arvalid,
    input  logic                 arready,
    input  logic [31:0]          rdata,
    input  logic                 rlast,
    input  logic                 rvalid,
    output logic                 rready
);

    logic [`ICACHE_LEN_RAM_ADDR-1:0] rd_addr;
    icache_pkg::way_wr_s way_wr;
    logic [`ICACHE_NR_WAYS-1:0] data_we;
    logic [`ICACHE_NR_WAYS-1:0] tag_we;
    logic [`ICACHE_LEN_TAG-1:0] cache_tag;
    icache_pkg::way_rd_s way_rd [`ICACHE_NR_WAYS];
    logic hit;
    logic [`ICACHE_LEN_WAY_SEL-1:0] hit_way;
    logic [31:0] hit_inst0;
    logic [31:0] hit_inst1;

    icache_ctrl ctrl_i (
        .clk, .rst, .inst_en, .inst_va, .inst_va_next,
        .inst_rdata0, .inst_rdata1, .inst_ok0, .inst_ok1,
        .inst_tlb_refill, .inst_tlb_invalid, .stallF, .istall,
        .fence_i, .fence_addr, .fence_tlb,
        .itlb_vpn2, .itlb_found, .itlb_entry,
        .araddr, .arlen, .arsize, .arvalid, .arready,
        .rdata, .rlast, .rvalid, .rready,
        .rd_addr, .way_wr, .data_we, .tag_we, .cache_tag,
        .hit, .hit_way, .hit_inst0, .hit_inst1
    );

    for (genvar i = 0; i < `ICACHE_NR_WAYS; i++) begin : g_way
        icache_way way_i (
            .clk       (clk),
            .rd_addr   (rd_addr),
            .cache_tag (cache_tag),
            .way_wr    (way_wr),
            .data_we   (data_we[i]),
            .tag_we    (tag_we[i]),
            .way_rd    (way_rd[i])
        );
    end

    icache_hit_select hit_select_i (
        .inst_va2  (inst_va[2]),
        .way_rd    (way_rd),
        .hit       (hit),
        .hit_way   (hit_way),
        .hit_inst0 (hit_inst0),
        .hit_inst1 (hit_inst1)
    );

endmodule

// File: verif/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk
);

    // period 20
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

endmodule

// File: verif/icache_assert.sv
module icache_assert (
    input logic clk,
    input logic rst,
    input logic arvalid,
    input logic arready,
    input logic rready,
    input logic inst_tlb_refill,
    input logic inst_tlb_invalid
);

    // address stays offered until the slave takes it
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");

    // request and data phases never overlap
    ar_r_excl: assert property (@(posedge clk) disable iff (rst)
        !(arvalid && rready))
        else $error("arvalid and rready high together");

    tlb_flags: assert property (@(posedge clk) disable iff (rst)
        !(inst_tlb_refill && inst_tlb_invalid))
        else $error("tlb refill and tlb invalid high together");

endmodule

// File: verif/icache_tb.sv
`include "icache_params.svh"

module icache_tb;

    localparam int num_init = `ICACHE_NR_SETS;
    localparam int num_ops = num_init + 400;
    // fence plus tlb fill plus a full burst under heavy back-pressure
    localparam int worst_cycles = 300;
    localparam longint timeout = longint'(num_ops) * worst_cycles * 20;
    localparam logic [31:0] mem_key = 32'h5a5a_0f0f;

    logic clk;
    logic rst;
    logic inst_en;
    logic [31:0] inst_va;
    logic [31:0] inst_va_next;
    logic [31:0] inst_rdata0;
    logic [31:0] inst_rdata1;
    logic inst_ok0;
    logic inst_ok1;
    logic inst_tlb_refill;
    logic inst_tlb_invalid;
    logic stallF;
    logic istall;
    logic fence_i;
    logic [31:0] fence_addr;
    logic fence_tlb;
    logic [18:0] itlb_vpn2;
    logic itlb_found;
    icache_pkg::tlb_entry itlb_entry;
    logic [31:0] araddr;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic arvalid;
    logic arready;
    logic [31:0] rdata;
    logic rlast;
    logic rvalid;
    logic rready;

    // joint TLB indexed by vpn2 0..7
    icache_pkg::tlb_entry jtlb [8];
    logic jtlb_found [8];

    // resident lines per set
    logic model_valid [`ICACHE_NR_SETS][`ICACHE_NR_WAYS];
    logic [`ICACHE_LEN_TAG-1:0] model_tag [`ICACHE_NR_SETS][`ICACHE_NR_WAYS];
    logic model_lru [`ICACHE_NR_SETS];

    logic [31:0] rand_state;
    int error_count;
    logic [31:0] nxt_va;
    logic nxt_fence_i;
    logic [31:0] nxt_fence_addr;
    logic nxt_fence_tlb;
    logic exp_refill;
    logic exp_invalid;
    logic [31:0] exp_data0;
    logic [31:0] exp_data1;
    logic exp_ok1;
    int exp_ar_count;
    logic [31:0] exp_araddr;
    logic [7:0] exp_arlen;
    int ar_count;
    logic ar_hs;
    logic r_hs;
    logic [31:0] seen_araddr;
    logic [7:0] seen_arlen;
    logic [31:0] burst_addr;
    int burst_left;

    tb_clock_gen clock_i (.clk);

    icache_top dut_i (.*);

    bind icache_top icache_assert assert_i (
        .clk, .rst, .arvalid, .arready, .rready, .inst_tlb_refill, .inst_tlb_invalid
    );

    // next fetch address only moves on when the current one is accepted
    assign inst_va_next = (!inst_en || (!istall && !stallF)) ? nxt_va : inst_va;

    always_comb begin
        itlb_found = 1'b0;
        itlb_entry = '0;
        if (itlb_vpn2 < 19'd8 && jtlb_found[itlb_vpn2[2:0]]) begin
            itlb_found = 1'b1;
            itlb_entry = jtlb[itlb_vpn2[2:0]];
        end
    end

    function automatic logic [31:0] rand_word();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic int roll(input int n);
        logic [31:0] r;
        r = rand_word();
        return int'(r[31:16]) % n;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] pa);
        return pa ^ mem_key;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            error_count++;
            $display("error at %0t: %s is %h, expected %h (va %h)",
                     $time, what, got, want, inst_va);
            $display("Done: errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic rewrite_entry(input int e);
        jtlb_found[e] = roll(4) != 0;
        jtlb[e].vpn2 = 19'(e);
        jtlb[e].pfn0 = 20'(roll(4));
        jtlb[e].pfn1 = 20'(roll(4));
        jtlb[e].v0 = roll(4) != 0;
        jtlb[e].v1 = roll(4) != 0;
        jtlb[e].c0 = roll(4) != 0;
        jtlb[e].c1 = roll(4) != 0;
    endtask

    task automatic plan_op(input int idx);
        int seg;
        // first pass fences every set with a fetch into it
        if (idx < num_init) begin
            nxt_va = 32'h8000_0000 | (idx << `ICACHE_LEN_LINE);
            nxt_fence_i = 1'b1;
            nxt_fence_addr = nxt_va;
            nxt_fence_tlb = 1'b0;
            return;
        end
        seg = roll(20);
        if (roll(2) == 0) begin
            nxt_va = nxt_va + 32'd4;
        end else if (seg < 10) begin
            nxt_va = 32'h8000_0000 | (rand_word() & 32'h3ffc);
        end else if (seg < 13) begin
            nxt_va = 32'ha000_0000 | (rand_word() & 32'h3ffc);
        end else begin
            nxt_va = rand_word() & 32'hfffc;
        end
        nxt_fence_i = roll(10) == 0;
        nxt_fence_addr = rand_word();
        nxt_fence_tlb = roll(10) == 0;
    endtask

    task automatic predict(input logic [31:0] va);
        logic [18:0] vpn2;
        logic odd;
        logic [31:0] pa;
        logic cached;
        logic [`ICACHE_LEN_INDEX-1:0] set;
        logic [`ICACHE_LEN_TAG-1:0] tag;
        int way;
        vpn2 = va[31:13];
        odd = va[12];
        exp_refill = 1'b0;
        exp_invalid = 1'b0;
        exp_data0 = '0;
        exp_data1 = '0;
        exp_ok1 = 1'b0;
        exp_ar_count = 0;
        if (va[31:30] == 2'b10) begin
            pa = {3'b000, va[28:0]};
            cached = !va[29];
        end else if (vpn2 >= 19'd8 || !jtlb_found[vpn2[2:0]]) begin
            exp_refill = 1'b1;
            return;
        end else if (!(odd ? jtlb[vpn2[2:0]].v1 : jtlb[vpn2[2:0]].v0)) begin
            exp_invalid = 1'b1;
            return;
        end else begin
            pa = {odd ? jtlb[vpn2[2:0]].pfn1 : jtlb[vpn2[2:0]].pfn0, va[11:0]};
            cached = odd ? jtlb[vpn2[2:0]].c1 : jtlb[vpn2[2:0]].c0;
        end
        exp_data0 = mem_word(pa);
        if (!cached) begin
            exp_ar_count = 1;
            exp_araddr = pa;
            exp_arlen = 8'd0;
            return;
        end
        exp_ok1 = !pa[2];
        exp_data1 = mem_word(pa + 32'd4);
        set = pa[`ICACHE_LEN_LINE +: `ICACHE_LEN_INDEX];
        tag = pa[31 -: `ICACHE_LEN_TAG];
        way = -1;
        for (int w = 0; w < `ICACHE_NR_WAYS; w++) begin
            if (model_valid[set][w] && model_tag[set][w] == tag) begin
                way = w;
            end
        end
        // miss replaces the least recently used way
        if (way < 0) begin
            way = model_lru[set] ? 1 : 0;
            model_valid[set][way] = 1'b1;
            model_tag[set][way] = tag;
            exp_ar_count = 1;
            exp_araddr = {pa[31:`ICACHE_LEN_LINE], {`ICACHE_LEN_LINE{1'b0}}};
            exp_arlen = 8'(`ICACHE_NR_WORDS - 1);
        end
        model_lru[set] = way == 0;
    endtask

    task automatic start_op(input int idx);
        if (nxt_fence_tlb) begin
            rewrite_entry(roll(8));
        end
        if (nxt_fence_i) begin
            for (int w = 0; w < `ICACHE_NR_WAYS; w++) begin
                model_valid[nxt_fence_addr[`ICACHE_LEN_LINE +: `ICACHE_LEN_INDEX]][w] = 1'b0;
            end
        end
        predict(nxt_va);
        ar_count = 0;
        inst_en = 1'b1;
        inst_va = nxt_va;
        fence_i = nxt_fence_i;
        fence_addr = nxt_fence_addr;
        fence_tlb = nxt_fence_tlb;
        plan_op(idx + 1);
    endtask

    task automatic watch_read_channel();
        ar_hs = arvalid && arready;
        r_hs = rvalid && rready;
        if (ar_hs) begin
            ar_count++;
            seen_araddr = araddr;
            seen_arlen = arlen;
            check_value("read request count", ar_count, exp_ar_count);
            check_value("araddr", araddr, exp_araddr);
            check_value("arlen", arlen, exp_arlen);
            check_value("arsize", arsize, 32'd2);
        end
    endtask

    // memory side serves one request at a time with random delays
    task automatic respond_read();
        if (ar_hs) begin
            burst_addr = seen_araddr;
            burst_left = int'(seen_arlen) + 1;
        end
        if (r_hs) begin
            burst_addr = burst_addr + 32'd4;
            burst_left--;
        end
        arready = burst_left == 0 && roll(3) != 0;
        if (!rvalid || r_hs) begin
            rvalid = burst_left != 0 && roll(3) != 0;
        end
        rdata = mem_word(burst_addr);
        rlast = burst_left == 1;
    endtask

    task automatic check_result();
        check_value("inst_ok0", inst_ok0, 32'd1);
        check_value("inst_tlb_refill", inst_tlb_refill, exp_refill);
        check_value("inst_tlb_invalid", inst_tlb_invalid, exp_invalid);
        check_value("inst_rdata0", inst_rdata0, exp_data0);
        check_value("inst_ok1", inst_ok1, exp_ok1);
        if (exp_ok1) begin
            check_value("inst_rdata1", inst_rdata1, exp_data1);
        end
        // every exception comes from a fresh joint TLB lookup
        if (exp_refill || exp_invalid) begin
            check_value("itlb_vpn2", itlb_vpn2, inst_va[31:13]);
        end
        check_value("read request count", ar_count, exp_ar_count);
    endtask

    initial begin : stimulus
        logic done;
        rand_state = 32'h9bf80c0d;
        error_count = 0;
        rst = 1'b1;
        inst_en = 1'b0;
        inst_va = '0;
        stallF = 1'b0;
        fence_i = 1'b0;
        fence_addr = '0;
        fence_tlb = 1'b0;
        arready = 1'b0;
        rdata = '0;
        rlast = 1'b0;
        rvalid = 1'b0;
        burst_addr = '0;
        burst_left = 0;
        ar_hs = 1'b0;
        r_hs = 1'b0;
        exp_araddr = '0;
        exp_arlen = '0;
        for (int s = 0; s < `ICACHE_NR_SETS; s++) begin
            model_lru[s] = 1'b0;
            for (int w = 0; w < `ICACHE_NR_WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w] = '0;
            end
        end
        for (int e = 0; e < 8; e++) begin
            rewrite_entry(e);
        end
        nxt_va = '0;
        plan_op(0);
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int op = 0; op < num_ops; op++) begin
            start_op(op);
            done = 1'b0;
            while (!done) begin
                @(negedge clk);
                watch_read_channel();
                if (!istall && !stallF) begin
                    check_result();
                    done = 1'b1;
                end
                @(posedge clk);
                #1;
                respond_read();
                stallF = roll(4) == 0;
            end
        end
        if (error_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "run ended with mismatches");
        end
    end

    initial begin : watchdog
        #(timeout);
        $display("timeout: fetches did not finish within %0d time units", timeout);
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: tb.f
+incdir+logic
logic/icache_pkg.sv
logic/icache_way.sv
logic/icache_hit_select.sv
logic/icache_ctrl.sv
logic/icache_top.sv
verif/tb_clock_gen.sv
verif/icache_assert.sv
verif/icache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the icache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f tb.f \
        --top-module icache_tb -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vicache_tb; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
exit 0
